//--- dv/tb_data_io.sv
/*
 * data_io testbench
 * drives file server transactions on SS2 and raw sectors on SS4, keeps
 * the expected writes in a queue and checks every ioctl_wr against it
 */
`timescale 1ns/100ps
`include "dio_defines.svh"

module tb_data_io;
	import dio_pkg::*;

	// expected write, address and byte side by side
	typedef struct packed {
		dio_addr_t addr;
		dio_byte_t data;
	} wr_exp_t;

	// clkref_n drive modes
	localparam int REF_RAND = 0;
	localparam int REF_HIGH = 1;
	localparam int REF_LOW = 2;

	// SPI_SCK periods of the whole run
	// reset, idle, index+start, 16 data, clkref cases, end+start+4, sector
	localparam int RUN_BITS = 3 + 20 + 36 + 138 + 74 + 78 + 4114;

	logic SPI_SCK;
	logic SPI_SS2;
	logic SPI_SS4;
	logic SPI_DI;
	logic SPI_DO;
	logic clk_sys;
	logic clkref_n;
	logic ioctl_download;
	dio_index_t ioctl_index;
	logic ioctl_wr;
	dio_addr_t ioctl_addr;
	dio_byte_t ioctl_dout;

	// scoreboard
	wr_exp_t exp_q[$];
	wr_exp_t head;
	dio_addr_t exp_addr = `DIO_START_ADDR;
	int ref_mode = REF_HIGH;
	int err_cnt = 0;
	int wr_cnt = 0;
	int test_cnt = 0;
	int fail_cnt = 0;
	int errs_base = 0;

	data_io dut0 (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_SS4        (SPI_SS4),
		.SPI_DI         (SPI_DI),
		.SPI_DO         (SPI_DO),
		.clk_sys        (clk_sys),
		.clkref_n       (clkref_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	initial begin
		SPI_SCK = 1'b0;
		forever #50 SPI_SCK = ~SPI_SCK;
	end

	// falling edges of SPI_SCK land on falling edges of clk_sys
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// clkref_n is a clk_sys input, so it moves on clk_sys falling edges
	always @(negedge clk_sys) begin
		case (ref_mode)
			REF_HIGH: clkref_n <= 1'b1;
			REF_LOW: clkref_n <= 1'b0;
			default: clkref_n <= $urandom % 2;
		endcase
	end

	// strobe is one cycle wide
	wr_one_cycle: assert property (@(posedge clk_sys) ioctl_wr |=> !ioctl_wr)
		else begin
			$display("ioctl_wr stayed high for more than one cycle at %0t", $time);
			err_cnt++;
		end

	// a write only follows a cycle with clkref_n low
	wr_in_slot: assert property (@(posedge clk_sys) ioctl_wr |-> $past(!clkref_n))
		else begin
			$display("ioctl_wr outside a clkref_n slot at %0t", $time);
			err_cnt++;
		end

	// compare each write with the queue head, mid cycle where outputs are stable
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			wr_cnt++;
			if (exp_q.size() == 0) begin
				$display("mismatch at %0t: unexpected write of %h at address %h",
					$time, ioctl_dout, ioctl_addr);
				err_cnt++;
			end else begin
				head = exp_q.pop_front();
				assert (ioctl_addr == head.addr && ioctl_dout == head.data) else begin
					$display("mismatch at %0t: wrote %h at %h, expected %h at %h",
						$time, ioctl_dout, ioctl_addr, head.data, head.addr);
					err_cnt++;
				end
			end
		end
	end

	// one byte msb first, the rising edge in between samples each bit
	task automatic shift_byte(input dio_byte_t b, input bit on_do);
		for (int i = 7; i >= 0; i--) begin
			if (on_do) begin
				SPI_DO = b[i];
			end else begin
				SPI_DI = b[i];
			end
			@(negedge SPI_SCK);
		end
	endtask

	task automatic send_cmd(input dio_byte_t op, input dio_byte_t payload[$]);
		@(negedge SPI_SCK);
		SPI_SS2 = 1'b0;
		shift_byte(op, 1'b0);
		foreach (payload[i]) begin
			shift_byte(payload[i], 1'b0);
		end
		SPI_SS2 = 1'b1;
		@(negedge SPI_SCK);
	endtask

	task automatic send_one(input dio_byte_t op, input dio_byte_t b);
		dio_byte_t q[$];
		q.push_back(b);
		send_cmd(op, q);
	endtask

	task automatic send_sector(input dio_byte_t bytes[$]);
		@(negedge SPI_SCK);
		SPI_SS4 = 1'b0;
		foreach (bytes[i]) begin
			shift_byte(bytes[i], 1'b1);
		end
		SPI_SS4 = 1'b1;
		@(negedge SPI_SCK);
	endtask

	task automatic expect_write(input dio_byte_t b);
		exp_q.push_back('{addr: exp_addr, data: b});
		exp_addr = exp_addr + 25'd1;
	endtask

	// mode changes on the rising edge, away from the driver
	task automatic set_ref(input int mode);
		@(posedge clk_sys);
		ref_mode = mode;
	endtask

	task automatic wait_drain();
		int n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(posedge clk_sys);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected writes never appeared by %0t", exp_q.size(), $time);
			err_cnt++;
			exp_q.delete();
		end
	endtask

	task automatic wait_download(input logic level);
		int n = 0;
		while (ioctl_download !== level && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		assert (ioctl_download === level) else begin
			$display("ioctl_download did not go to %0b by %0t", level, $time);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == errs_base) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: FAILED", test_cnt, name);
			fail_cnt++;
		end
		errs_base = err_cnt;
	endtask

	// run limit, twice the SPI time of all tests
	initial begin
		#(RUN_BITS * 100 * 2);
		$display("timeout: the run did not finish in time, stopped at %0t", $time);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		dio_byte_t bytes[$];
		dio_byte_t b;
		int wr_before;

		void'($urandom(32'hd13cb682));
		SPI_SS2 = 1'b1;
		SPI_SS4 = 1'b1;
		SPI_DI = 1'b0;
		SPI_DO = 1'b0;
		clkref_n = 1'b1;
		repeat (3) @(negedge SPI_SCK);
		set_ref(REF_RAND);

		// nothing sent, nothing written
		repeat (20) begin
			@(negedge SPI_SCK);
			assert (!ioctl_wr && !ioctl_download) else begin
				$display("mismatch at %0t: ioctl_wr or ioctl_download high while idle",
					$time);
				err_cnt++;
			end
		end
		end_test("idle after reset");

		// index first, latched by the start that follows
		send_one(`DIO_FILE_INDEX, 8'h3c);
		exp_addr = `DIO_START_ADDR;
		send_one(`DIO_FILE_TX, 8'h01);
		wait_download(1'b1);
		repeat (2) @(negedge clk_sys);
		assert (ioctl_index == 8'h3c) else begin
			$display("mismatch at %0t: ioctl_index %h, expected 3c", $time, ioctl_index);
			err_cnt++;
		end
		end_test("index and transfer start");

		// sixteen bytes in one transaction
		wr_before = wr_cnt;
		for (int i = 0; i < 16; i++) begin
			b = dio_byte_t'($urandom);
			bytes.push_back(b);
			expect_write(b);
		end
		send_cmd(`DIO_FILE_TX_DAT, bytes);
		wait_drain();
		// a repeated strobe for the last byte would show up here
		repeat (50) @(negedge clk_sys);
		assert (wr_cnt - wr_before == 16) else begin
			$display("mismatch at %0t: %0d writes seen for 16 data bytes",
				$time, wr_cnt - wr_before);
			err_cnt++;
		end
		end_test("random data bytes");

		// byte held back while no slot is offered
		set_ref(REF_HIGH);
		wr_before = wr_cnt;
		b = dio_byte_t'($urandom);
		expect_write(b);
		send_one(`DIO_FILE_TX_DAT, b);
		repeat (30) @(negedge SPI_SCK);
		assert (wr_cnt == wr_before && exp_q.size() == 1) else begin
			$display("mismatch at %0t: byte written while clkref_n was held high", $time);
			err_cnt++;
		end
		set_ref(REF_LOW);
		wait_drain();
		// slot open every cycle, strobe still one cycle per byte
		bytes.delete();
		for (int i = 0; i < 2; i++) begin
			b = dio_byte_t'($urandom);
			bytes.push_back(b);
			expect_write(b);
		end
		send_cmd(`DIO_FILE_TX_DAT, bytes);
		wait_drain();
		set_ref(REF_RAND);
		end_test("clkref_n slot wait");

		// end, then a fresh start restarts the address
		send_one(`DIO_FILE_TX, 8'h00);
		wait_download(1'b0);
		exp_addr = `DIO_START_ADDR;
		send_one(`DIO_FILE_TX, 8'h01);
		wait_download(1'b1);
		bytes.delete();
		for (int i = 0; i < 4; i++) begin
			b = dio_byte_t'($urandom);
			bytes.push_back(b);
			expect_write(b);
		end
		send_cmd(`DIO_FILE_TX_DAT, bytes);
		wait_drain();
		end_test("transfer end and restart");

		// sector, the two crc bytes must not show up
		wr_before = wr_cnt;
		bytes.delete();
		for (int i = 0; i < `DIO_SECTOR_BYTES; i++) begin
			b = dio_byte_t'($urandom);
			bytes.push_back(b);
			if (i < `DIO_SECTOR_DATA) begin
				expect_write(b);
			end
		end
		send_sector(bytes);
		wait_drain();
		repeat (50) @(negedge clk_sys);
		assert (wr_cnt - wr_before == `DIO_SECTOR_DATA) else begin
			$display("mismatch at %0t: %0d writes seen for one sector",
				$time, wr_cnt - wr_before);
			err_cnt++;
		end
		end_test("direct sector upload");

		$display("tests: %0d run, %0d failed, %0d errors, %0d writes checked",
			test_cnt, fail_cnt, err_cnt, wr_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- logic/data_io.sv
/*
 * data_io download block
 * SPI command and sector receivers feeding the clk_sys write sequencer
 */
`timescale 1ns/100ps
`include "dio_defines.svh"

module data_io (
	input  logic                SPI_SCK,
	input  logic                SPI_SS2,
	input  logic                SPI_SS4,
	input  logic                SPI_DI,
	// SPI_DO is an input while SS4 selects the sector stream
	input  logic                SPI_DO,
	input  logic                clk_sys,
	input  logic                clkref_n,
	output logic                ioctl_download,
	output dio_pkg::dio_index_t ioctl_index,
	output logic                ioctl_wr,
	output dio_pkg::dio_addr_t  ioctl_addr,
	output dio_pkg::dio_byte_t  ioctl_dout
);
	import dio_pkg::*;

	dio_cmd_flags_t cmd_flags;
	dio_sector_flags_t sector_flags;

	dio_cmd_rx u_cmd_rx (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS2   (SPI_SS2),
		.SPI_DI    (SPI_DI),
		.cmd_flags (cmd_flags)
	);

	// sector path only in builds with direct upload
	generate
		if (`DIO_ROM_DIRECT_UPLOAD == 1) begin : g_sector
			dio_sector_rx u_sector_rx (
				.SPI_SCK      (SPI_SCK),
				.SPI_SS4      (SPI_SS4),
				.SPI_DO       (SPI_DO),
				.sector_flags (sector_flags)
			);
		end else begin : g_no_sector
			// a toggle that never moves means no sector writes
			assign sector_flags = '0;
		end
	endgenerate

	dio_write_seq u_write_seq (
		.clk_sys        (clk_sys),
		.clkref_n       (clkref_n),
		.cmd_flags      (cmd_flags),
		.sector_flags   (sector_flags),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

//--- logic/dio_cmd_rx.sv
/*
 * data_io command receiver
 * shifts bytes in on SPI_SCK while SPI_SS2 is low, decodes the leading
 * command byte and publishes file bytes, the menu index and the
 * download state with toggle flags for the clk_sys side
 */
`timescale 1ns/100ps
`include "dio_defines.svh"

module dio_cmd_rx (
	input  logic                    SPI_SCK,
	input  logic                    SPI_SS2,
	input  logic                    SPI_DI,
	output dio_pkg::dio_cmd_flags_t cmd_flags = '0
);
	import dio_pkg::*;

	// bit position, 0-7 for the command then 8-15 per payload byte
	logic [3:0] bit_cnt;
	// first seven bits of the byte in flight, msb first
	logic [6:0] sbuf = '0;
	// opcode of the running transaction
	dio_byte_t cmd = '0;
	// whole byte with the eighth bit taken live from the pin
	dio_byte_t rx_byte;
	logic cmd_done;
	logic byte_done;

	assign rx_byte = {sbuf, SPI_DI};
	assign cmd_done = (bit_cnt == 4'd7);
	assign byte_done = (bit_cnt == 4'd15);

	// only the bit counter sees chip select
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			bit_cnt <= 4'd0;
		end else if (byte_done) begin
			// wrap to the first bit of the next payload byte
			bit_cnt <= 4'd8;
		end else begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// flags keep their value across chip select so no write gets lost
	always_ff @(posedge SPI_SCK) begin
		sbuf <= {sbuf[5:0], SPI_DI};

		if (cmd_done) begin
			cmd <= rx_byte;
		end

		// eighth bit of a payload byte
		if (byte_done) begin
			case (cmd)
				`DIO_FILE_TX: begin
					// bit 0 set opens a transfer, clear closes it
					cmd_flags.downloading <= SPI_DI;
					if (SPI_DI) begin
						cmd_flags.start_tgl <= ~cmd_flags.start_tgl;
					end
				end
				`DIO_FILE_TX_DAT: begin
					cmd_flags.data <= rx_byte;
					cmd_flags.data_tgl <= ~cmd_flags.data_tgl;
				end
				`DIO_FILE_INDEX: begin
					// picked up by the sequencer at the next start
					cmd_flags.index <= rx_byte;
				end
				default: begin
					// other opcodes are ignored
				end
			endcase
		end
	end

endmodule

//--- logic/dio_defines.svh
/*
 * data_io download block constants
 * command opcodes of the file server, first write address of a
 * transfer, SD sector geometry and the direct sector upload switch
 */
`ifndef DIO_DEFINES_SVH
`define DIO_DEFINES_SVH

// opcodes sent as the first byte of an SS2 transaction
`define DIO_FILE_TX          8'h53
`define DIO_FILE_TX_DAT      8'h54
`define DIO_FILE_INDEX       8'h55

// address of the first byte written in every transfer
`define DIO_START_ADDR       25'h0

// 1 builds the raw SD sector receiver on SS4
`define DIO_ROM_DIRECT_UPLOAD 1

// 512 payload bytes followed by 2 crc bytes
`define DIO_SECTOR_BYTES     514
`define DIO_SECTOR_DATA      512

`endif

//--- logic/dio_pkg.sv
/*
 * data_io types
 * byte, address and index widths plus the flag bundles that the
 * SPI receivers hand over to the clk_sys write sequencer
 */
package dio_pkg;

	// one byte on the memory side
	typedef logic [7:0] dio_byte_t;
	// write address into the core memory
	typedef logic [24:0] dio_addr_t;
	// menu index of the file being sent
	typedef logic [7:0] dio_index_t;

	// command receiver state seen by the sequencer
	typedef struct packed {
		dio_byte_t  data;
		logic       data_tgl;
		logic       start_tgl;
		logic       downloading;
		dio_index_t index;
	} dio_cmd_flags_t;

	// sector receiver state, one byte and its toggle
	typedef struct packed {
		dio_byte_t data;
		logic      data_tgl;
	} dio_sector_flags_t;

endpackage

//--- logic/dio_sector_rx.sv
/*
 * data_io direct sector receiver
 * takes raw SD sectors on SPI_DO while SPI_SS4 is low and passes the
 * 512 payload bytes on with a toggle, the two crc bytes are dropped
 */
`timescale 1ns/100ps
`include "dio_defines.svh"

module dio_sector_rx (
	input  logic                       SPI_SCK,
	input  logic                       SPI_SS4,
	input  logic                       SPI_DO,
	output dio_pkg::dio_sector_flags_t sector_flags = '0
);
	import dio_pkg::*;

	// bit within the byte
	logic [2:0] bit_cnt;
	// byte within the sector, 0 to 513
	logic [9:0] byte_cnt;
	// first seven bits of the byte in flight
	logic [6:0] sbuf = '0;
	logic byte_done;
	logic last_byte;
	logic payload;

	assign byte_done = (bit_cnt == 3'd7);
	assign last_byte = (byte_cnt == 10'(`DIO_SECTOR_BYTES - 1));
	// crc bytes sit at the end of the sector
	assign payload = (byte_cnt < 10'(`DIO_SECTOR_DATA));

	// counters restart with each SS4 select
	always_ff @(posedge SPI_SCK or posedge SPI_SS4) begin
		if (SPI_SS4) begin
			bit_cnt <= 3'd0;
			byte_cnt <= 10'd0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (byte_done) begin
				// back-to-back sectors in one select
				if (last_byte) begin
					byte_cnt <= 10'd0;
				end else begin
					byte_cnt <= byte_cnt + 10'd1;
				end
			end
		end
	end

	always_ff @(posedge SPI_SCK) begin
		sbuf <= {sbuf[5:0], SPI_DO};
		// bit_cnt stays 0 while deselected so nothing is captured then
		if (byte_done && payload) begin
			sector_flags.data <= {sbuf, SPI_DO};
			sector_flags.data_tgl <= ~sector_flags.data_tgl;
		end
	end

endmodule

//--- logic/dio_write_seq.sv
/*
 * data_io write sequencer
 * brings the receiver toggles into clk_sys, waits for a clkref_n slot
 * and issues one ioctl_wr pulse per byte at an incrementing address
 */
`timescale 1ns/100ps
`include "dio_defines.svh"

module dio_write_seq (
	input  logic                       clk_sys,
	input  logic                       clkref_n,
	input  dio_pkg::dio_cmd_flags_t    cmd_flags,
	input  dio_pkg::dio_sector_flags_t sector_flags,
	output logic                       ioctl_download = 1'b0,
	output logic                       ioctl_wr = 1'b0,
	output dio_pkg::dio_index_t        ioctl_index = '0,
	output dio_pkg::dio_addr_t         ioctl_addr = '0,
	output dio_pkg::dio_byte_t         ioctl_dout = '0
);
	import dio_pkg::*;

	// bit positions in the synchroniser vectors
	localparam int TGL_SEC = 0;
	localparam int TGL_DAT = 1;
	localparam int TGL_START = 2;
	localparam int LVL_DL = 3;

	// raw SPI domain signals, toggles in the low three bits
	logic [3:0] sync_in;
	// two synchroniser stages
	logic [3:0] sync_1 = '0;
	logic [3:0] sync_2 = '0;
	// delayed copy of the toggles for change detection
	logic [2:0] tgl_3 = '0;
	logic [2:0] tgl_edge;
	// one byte waiting per receiver
	logic cmd_pend = 1'b0;
	logic sec_pend = 1'b0;
	// next address to be written
	dio_addr_t addr = `DIO_START_ADDR;
	logic wr_slot;

	assign sync_in = {cmd_flags.downloading, cmd_flags.start_tgl,
		cmd_flags.data_tgl, sector_flags.data_tgl};
	assign tgl_edge = sync_2[2:0] ^ tgl_3;
	// clkref_n low marks the cycle the core accepts a write
	assign wr_slot = !clkref_n && (cmd_pend || sec_pend);

	always_ff @(posedge clk_sys) begin
		sync_1 <= sync_in;
		sync_2 <= sync_1;
		tgl_3 <= sync_2[2:0];
	end

	always_ff @(posedge clk_sys) begin
		// single cycle strobe
		ioctl_wr <= 1'b0;
		ioctl_download <= sync_2[LVL_DL];

		if (wr_slot) begin
			ioctl_wr <= 1'b1;
			ioctl_addr <= addr;
			addr <= addr + 25'd1;
			// command byte wins, the sector byte waits for the next slot
			if (cmd_pend) begin
				ioctl_dout <= cmd_flags.data;
				cmd_pend <= 1'b0;
			end else begin
				ioctl_dout <= sector_flags.data;
				sec_pend <= 1'b0;
			end
		end

		// transfer start overrides any increment in the same cycle
		if (tgl_edge[TGL_START]) begin
			addr <= `DIO_START_ADDR;
			ioctl_index <= cmd_flags.index;
		end

		// a fresh byte keeps its pending flag even if the old one just went out
		if (tgl_edge[TGL_DAT]) begin
			cmd_pend <= 1'b1;
		end
		if (tgl_edge[TGL_SEC]) begin
			sec_pend <= 1'b1;
		end
	end

endmodule

//--- project.f
+incdir+logic
logic/dio_pkg.sv
logic/dio_cmd_rx.sv
logic/dio_sector_rx.sv
logic/dio_write_seq.sv
logic/data_io.sv
dv/tb_data_io.sv
